//--- sources.f
+incdir+verilog
verilog/bus_cycle_if.sv
verilog/progress_pkg.sv
verilog/byte_lane_sel.sv
verilog/bus_cycle_ctrl.sv
verilog/ack_qualifier.sv
verilog/ucode_progress.sv
verilog/progress_ctrl.sv
test/tb_progress_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_progress_ctrl -f sources.f || exit 1
sim_out=$(./obj_dir/Vtb_progress_ctrl)
printf '%s\n' "$sim_out"
# The run counts as passed only when the pass line shows up on its own
printf '%s\n' "$sim_out" | grep -qx "NO ERRORS" && echo "simulation passed" || {
   echo "simulation failed"
   exit 1
}

//--- test/progress_testdata.txt
# ctl: corerunning ACK_I sysregack sram_ack buserror  sa: sa14 sa15 sa30 sa32 sa33 sa41 sa42 sa43
# shf: lastshift rlastshift, lane sa27..sa24 hex, B hex, expected SEL_O bmask hex
# out: iwe ctrlreg_we WE_O STB_O sram_stb enaQ progress_ucode qACK
10000 10000000 00 0 00000000 0 f 10000010
10000 10000100 00 1 00000000 0 f 00000010
10000 10000100 00 1 00000001 3 c 00000010
10000 10000100 00 1 00000002 f 0 00000010
10000 10000100 00 1 00000003 c 3 00000010
10000 10000100 00 2 00000000 f 0 00000010
10000 10000100 00 2 00000001 1 e 00000010
10000 10000100 00 2 00000002 2 d 00000010
10000 10000100 00 2 00000003 4 b 00000010
10000 10000100 00 7 00000001 8 7 00000010
10000 10000000 00 2 00000000 f 0 10000010
# I/O strobe held until ACK_I
10000 10000010 00 0 40000000 f 0 10000010
10000 11000000 00 0 00000000 f 0 10010000
10000 11000000 00 0 00000000 f 0 10010000
11000 11000000 00 0 00000000 f 0 10010001
10000 11000000 00 0 00000000 f 0 10000110
# SRAM strobe held until sram_ack
10000 10000010 00 0 80000000 f 0 10000010
10000 10010000 00 0 00000000 f 0 10001000
10010 10000000 00 0 00000000 f 0 10001000
10000 10000000 00 0 00000000 f 0 10000010
# Misaligned word store, core stopped, bus error abort
10000 10100010 00 0 40000002 f 0 10000010
00000 10000010 00 0 80000000 f 0 00000010
10000 10000000 00 0 00000000 f 0 10000010
10000 10000010 00 0 40000000 f 0 10000010
10000 10000000 00 0 00000000 f 0 10010000
10001 10000000 00 0 00000000 f 0 10010010
10000 10000000 00 0 00000000 f 0 10000010
# Write enables, control register region then plain I/O
10000 10000001 00 0 20000000 f 0 10000010
10000 10000000 00 0 00000000 f 0 11000010
10000 00000000 00 0 00000000 f 0 11000010
10000 10000000 00 0 00000000 f 0 10000010
10000 10000001 00 0 40000000 f 0 10000010
10000 10000000 00 0 00000000 f 0 00100010
10000 00000000 00 0 00000000 f 0 00100010
10000 10000000 00 0 00000000 f 0 10000010
# ACK_I stuck high, then system register acknowledge
11000 10000000 00 0 00000000 f 0 10000010
11000 10000010 00 0 40000000 f 0 10000010
11000 10000000 00 0 00000000 f 0 10010001
10100 10000000 00 0 00000000 f 0 10000011
10100 10000000 00 0 00000000 f 0 10000011
10000 10000010 00 0 40000000 f 0 10000010
10000 10000000 00 0 00000000 f 0 10010000
11000 10000000 00 0 00000000 f 0 10010001
10000 10000000 00 0 00000000 f 0 10000010
# Progress and Q enable decode
10000 11001000 00 0 00000000 f 0 10000100
10000 11001000 10 0 00000000 f 0 10000010
10000 11001000 01 0 00000000 f 0 00000110
10001 11001000 00 0 00000000 f 0 10000110
10000 10011000 00 0 00000000 f 0 10000100
10000 10000000 00 0 00000000 f 0 10000010

//--- test/tb_progress_ctrl.sv
`timescale 1ns/100ps

// Testbench for progress_ctrl
// Each data line sets the DUT inputs for one cycle and lists the outputs expected in it
module tb_progress_ctrl;

   localparam int    CLK_PERIOD   = 4;
   localparam int    RESET_CYCLES = 10;
   localparam int    SLACK_CYCLES = 20; // Margin on top of data and reset cycles
   localparam string DATA_FILE    = "test/progress_testdata.txt";

   logic clk = 1'b0;
   logic RST_I;
   logic corerunning;
   logic ACK_I;
   logic sysregack;
   logic sram_ack;
   logic sa14, sa15, sa24, sa25, sa26, sa27, sa30;
   logic sa32, sa33, sa41, sa42, sa43;
   logic lastshift;
   logic rlastshift;
   logic buserror;
   progress_pkg::adr_t B;
   progress_pkg::sel_t SEL_O;
   progress_pkg::sel_t bmask;
   logic iwe, ctrlreg_we, WE_O, STB_O, sram_stb, enaQ, progress_ucode, qACK;

   // One entry per data line
   logic [4:0]               ctl_q [$];       // corerunning ACK_I sysregack sram_ack buserror
   logic [7:0]               sa_q [$];        // sa14 sa15 sa30 sa32 sa33 sa41 sa42 sa43
   logic [1:0]               shift_q [$];     // lastshift rlastshift
   progress_pkg::lane_code_t lane_q [$];
   progress_pkg::adr_t       adr_q [$];
   progress_pkg::sel_t       exp_sel_q [$];
   progress_pkg::sel_t       exp_bmask_q [$];
   logic [7:0]               exp_out_q [$];   // Single-bit outputs, iwe first
   int                       line_q [$];      // Line number in the data file

   int mismatches   = 0;
   int other_errors = 0;
   bit loaded       = 1'b0; // Starts the watchdog once the line count is known

   always #(CLK_PERIOD / 2) clk = ~clk;

   progress_ctrl u_dut (
      .clk            (clk),
      .RST_I          (RST_I),
      .corerunning    (corerunning),
      .ACK_I          (ACK_I),
      .sysregack      (sysregack),
      .sram_ack       (sram_ack),
      .sa14           (sa14),
      .sa15           (sa15),
      .sa24           (sa24),
      .sa25           (sa25),
      .sa26           (sa26),
      .sa27           (sa27),
      .sa30           (sa30),
      .sa32           (sa32),
      .sa33           (sa33),
      .sa41           (sa41),
      .sa42           (sa42),
      .sa43           (sa43),
      .lastshift      (lastshift),
      .rlastshift     (rlastshift),
      .buserror       (buserror),
      .B              (B),
      .SEL_O          (SEL_O),
      .bmask          (bmask),
      .iwe            (iwe),
      .ctrlreg_we     (ctrlreg_we),
      .WE_O           (WE_O),
      .STB_O          (STB_O),
      .sram_stb       (sram_stb),
      .enaQ           (enaQ),
      .progress_ucode (progress_ucode),
      .qACK           (qACK)
   );

   // Read all lines up front, comment lines start with #
   task automatic load_testdata();
      int                       fd;
      int                       code;
      int                       file_line;
      string                    text;
      logic [4:0]               ctl;
      logic [7:0]               sa;
      logic [1:0]               shf;
      progress_pkg::lane_code_t lane;
      progress_pkg::adr_t       adr;
      progress_pkg::sel_t       e_sel;
      progress_pkg::sel_t       e_bmask;
      logic [7:0]               e_out;
      fd = $fopen(DATA_FILE, "r");
      if (fd == 0) begin
         $display("error: cannot open the data file %s", DATA_FILE);
         other_errors++;
      end else begin
         file_line = 0;
         while ($fgets(text, fd) > 0) begin
            file_line++;
            if (text.len() > 1 && text[0] != "#") begin
               code = $sscanf(text, "%b %b %b %h %h %h %h %b",
                              ctl, sa, shf, lane, adr, e_sel, e_bmask, e_out);
               if (code == 8) begin
                  ctl_q.push_back(ctl);
                  sa_q.push_back(sa);
                  shift_q.push_back(shf);
                  lane_q.push_back(lane);
                  adr_q.push_back(adr);
                  exp_sel_q.push_back(e_sel);
                  exp_bmask_q.push_back(e_bmask);
                  exp_out_q.push_back(e_out);
                  line_q.push_back(file_line);
               end else begin
                  $display("error: line %0d of the data file cannot be read", file_line);
                  other_errors++;
               end
            end
         end
         $fclose(fd);
         if (ctl_q.size() == 0) begin
            $display("error: the data file holds no test lines");
            other_errors++;
         end
      end
   endtask

   task automatic apply_inputs(input int i);
      {corerunning, ACK_I, sysregack, sram_ack, buserror} = ctl_q[i];
      {sa14, sa15, sa30, sa32, sa33, sa41, sa42, sa43}    = sa_q[i];
      {lastshift, rlastshift}                             = shift_q[i];
      {sa27, sa26, sa25, sa24}                            = lane_q[i];
      B                                                   = adr_q[i];
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp,
                              input int line);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: data line %0d, %s is %b, expected %b",
                  $time, line, name, got, exp);
      end
   endtask

   task automatic compare_lanes(input string name, input progress_pkg::sel_t got,
                                input progress_pkg::sel_t exp, input int line);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: data line %0d, %s is %b, expected %b",
                  $time, line, name, got, exp);
      end
   endtask

   task automatic check_outputs(input int i);
      logic [7:0] exp;
      exp = exp_out_q[i];
      compare_lanes("SEL_O", SEL_O, exp_sel_q[i], line_q[i]);
      compare_lanes("bmask", bmask, exp_bmask_q[i], line_q[i]);
      compare_bit("iwe", iwe, exp[7], line_q[i]);
      compare_bit("ctrlreg_we", ctrlreg_we, exp[6], line_q[i]);
      compare_bit("WE_O", WE_O, exp[5], line_q[i]);
      compare_bit("STB_O", STB_O, exp[4], line_q[i]);
      compare_bit("sram_stb", sram_stb, exp[3], line_q[i]);
      compare_bit("enaQ", enaQ, exp[2], line_q[i]);
      compare_bit("progress_ucode", progress_ucode, exp[1], line_q[i]);
      compare_bit("qACK", qACK, exp[0], line_q[i]);
   endtask

   initial begin
      int n;
      RST_I       = 1'b1;
      corerunning = 1'b0;
      ACK_I       = 1'b0;
      sysregack   = 1'b0;
      sram_ack    = 1'b0;
      buserror    = 1'b0;
      {sa14, sa15, sa30, sa32, sa33, sa41, sa42, sa43} = '0;
      {sa27, sa26, sa25, sa24} = '0;
      {lastshift, rlastshift}  = '0;
      B = '0;
      $timeformat(-9, 1, " ns", 0);
      load_testdata();
      n      = ctl_q.size();
      loaded = 1'b1;
      if (n > 0) begin
         repeat (RESET_CYCLES) @(posedge clk);
         for (int i = 0; i < n; i++) begin
            #1;
            RST_I = 1'b0; // First line sees the reset values
            apply_inputs(i);
            #2;           // Outputs settled, next edge still 1 ns away
            check_outputs(i);
            @(posedge clk);
         end
      end
      $display("summary: %0d data lines, %0d mismatches, %0d other errors",
               n, mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog, sized from the data lines plus reset and slack
   initial begin
      wait (loaded);
      #((ctl_q.size() + RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
      $display("timeout: the run did not end within the expected number of cycles");
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- verilog/progress_ctrl.sv
`timescale 1ns/100ps

// Progress and bus-cycle controller of the microcoded core
// Byte lanes, strobes, write enables, ack qualifier and ucode progress
module progress_ctrl (
   input  logic               clk,
   input  logic               RST_I,
   input  logic               corerunning,
   input  logic               ACK_I,          // I/O slave acknowledge
   input  logic               sysregack,      // System register acknowledge
   input  logic               sram_ack,       // SRAM acknowledge
   input  logic               sa14,           // Low clears write enables
   input  logic               sa15,           // Q enable
   input  logic               sa24,           // Lane code, bit 0
   input  logic               sa25,
   input  logic               sa26,
   input  logic               sa27,           // Lane code, bit 3
   input  logic               sa30,           // Word store alignment check
   input  logic               sa32,           // Read input
   input  logic               sa33,           // Shift repeat
   input  logic               sa41,           // Latch SEL_O
   input  logic               sa42,           // Start strobe
   input  logic               sa43,           // Set write enables
   input  logic               lastshift,
   input  logic               rlastshift,
   input  logic               buserror,
   input  progress_pkg::adr_t B,              // Address of the access
   output progress_pkg::sel_t SEL_O,
   output progress_pkg::sel_t bmask,
   output logic               iwe,
   output logic               ctrlreg_we,
   output logic               WE_O,
   output logic               STB_O,
   output logic               sram_stb,
   output logic               enaQ,
   output logic               progress_ucode,
   output logic               qACK
);

   progress_pkg::lane_code_t lane_code;

   bus_cycle_if u_bus ();

   assign lane_code = {sa27, sa26, sa25, sa24};

   byte_lane_sel u_lane (
      .clk       (clk),
      .RST_I     (RST_I),
      .sa41      (sa41),
      .lane_code (lane_code),
      .adr_lo    (B[1:0]),
      .sel       (SEL_O),
      .bmask     (bmask)
   );

   bus_cycle_ctrl u_cycle (
      .clk         (clk),
      .RST_I       (RST_I),
      .corerunning (corerunning),
      .sa42        (sa42),
      .sa43        (sa43),
      .sa14        (sa14),
      .sa30        (sa30),
      .buserror    (buserror),
      .sram_ack    (sram_ack),
      .adr         (B),
      .bus         (u_bus.cycle),
      .ctrlreg_we  (ctrlreg_we)
   );

   ack_qualifier u_ack (
      .clk       (clk),
      .RST_I     (RST_I),
      .ACK_I     (ACK_I),
      .sysregack (sysregack),
      .bus       (u_bus.ack)
   );

   ucode_progress u_prog (
      .corerunning    (corerunning),
      .sa15           (sa15),
      .sa32           (sa32),
      .sa33           (sa33),
      .sa41           (sa41),
      .lastshift      (lastshift),
      .rlastshift     (rlastshift),
      .buserror       (buserror),
      .bus            (u_bus.progress),
      .enaq           (enaQ),
      .progress_ucode (progress_ucode),
      .iwe            (iwe)
   );

   // Cycle status leaves the design as plain ports
   assign STB_O    = u_bus.stb_o;
   assign sram_stb = u_bus.sram_stb;
   assign WE_O     = u_bus.we_o;
   assign qACK     = u_bus.qack;

endmodule

//--- verilog/ucode_progress.sv
`timescale 1ns/100ps

// Microcode progress, Q-register enable and internal write enable
// Pure combinational, decoded from the microcode word and cycle status
module ucode_progress (
   input  logic          corerunning,
   input  logic          sa15,        // Part of the Q enable
   input  logic          sa32,        // Read input, also enables Q
   input  logic          sa33,        // Repeat shift until done
   input  logic          sa41,        // Byte select setup, no EBR write
   input  logic          lastshift,
   input  logic          rlastshift,
   input  logic          buserror,
   bus_cycle_if.progress bus,
   output logic          enaq,
   output logic          progress_ucode,
   output logic          iwe
);

   logic pending;   // A bus cycle is waiting for its acknowledge
   logic shift_end; // Shift loop finished or no loop requested
   logic no_iwe;

   assign pending = bus.stb_o | bus.sram_stb;

   // Q samples the ALU except at the end of a shift or while waiting on the bus
   assign enaq = (sa15 | sa32) & ~lastshift & ~pending;

   assign shift_end = ~sa33 | lastshift | rlastshift;

   // Bus error always moves on, so the trap sequence can run
   assign progress_ucode = (shift_end & ~pending) | buserror;

   // EBR write is blocked on lane setup, on external writes
   // and on a zero-length shift
   assign no_iwe = sa41 | bus.we_o | rlastshift;
   assign iwe    = corerunning & ~no_iwe; // No write before the core starts

endmodule

//--- verilog/ack_qualifier.sv
`timescale 1ns/100ps

// Qualified acknowledge for I/O cycles
// Tolerates a slave that holds ACK_I high all the time, Wishbone rule 3.55
// ACK_I seen without STB_O means such a slave, then STB_O is used instead
module ack_qualifier (
   input  logic     clk,
   input  logic     RST_I,
   input  logic     ACK_I,     // Acknowledge from the I/O slave
   input  logic     sysregack, // Acknowledge from the system registers
   bus_cycle_if.ack bus
);

   progress_pkg::ack_state_e state;
   progress_pkg::ack_state_e next_state;

   // Stay in R355 while ACK_I stays high, back to normal once it drops
   always_comb begin
      if (ACK_I && (!bus.stb_o || state == progress_pkg::ACK_R355)) begin
         next_state = progress_pkg::ACK_R355;
      end else begin
         next_state = progress_pkg::ACK_NORMAL;
      end
   end

   always_ff @(posedge clk) begin
      if (RST_I) begin
         state <= progress_pkg::ACK_NORMAL;
      end else begin
         state <= next_state;
      end
   end

   // System registers always answer in one cycle, whatever the state
   always_comb begin
      if (state == progress_pkg::ACK_R355) begin
         bus.qack = sysregack | bus.stb_o; // Zero wait states assumed
      end else begin
         bus.qack = sysregack | (ACK_I & bus.stb_o);
      end
   end

endmodule

//--- verilog/bus_cycle_ctrl.sv
`timescale 1ns/100ps
`include "progress_config.svh"

// Strobes and write enables for I/O and SRAM cycles
// A strobe is started by sa42 and held until its acknowledge
module bus_cycle_ctrl (
   input  logic               clk,
   input  logic               RST_I,
   input  logic               corerunning, // No bus activity before the core runs
   input  logic               sa42,        // Possibly start a strobe
   input  logic               sa43,        // Possibly set the write enables
   input  logic               sa14,        // Low clears the write enables
   input  logic               sa30,        // Word store, must be word aligned
   input  logic               buserror,
   input  logic               sram_ack,
   input  progress_pkg::adr_t adr,
   bus_cycle_if.cycle         bus,
   output logic               ctrlreg_we
);

   logic misaligned;
   logic io_hit;          // Address in the I/O region
   logic sram_hit;        // Address in the SRAM region
   logic ctrlreg_hit;     // Address in the control register region
   logic next_stb;
   logic next_sram_stb;
   logic stb_q;
   logic sram_stb_q;
   logic we_q;

   // A misaligned word store gets neither strobe nor write enable
   assign misaligned = ~corerunning | (sa30 & (adr[1] | adr[0]));

   assign io_hit      = ~adr[`PROG_SRAM_BIT] & adr[`PROG_IO_BIT];
   assign sram_hit    = adr[`PROG_SRAM_BIT];
   assign ctrlreg_hit = (adr[`PROG_ADR_W-1 -: 4] == `PROG_CTRLREG_REGION);

   // Start on sa42, hold until acknowledged
   assign next_stb      = (sa42 & io_hit & ~misaligned) | (stb_q & ~bus.qack);
   assign next_sram_stb = (sa42 & sram_hit & ~misaligned) | (sram_stb_q & ~sram_ack);

   always_ff @(posedge clk) begin
      if (RST_I | buserror) begin
         stb_q      <= 1'b0; // Bus error aborts the cycle
         sram_stb_q <= 1'b0;
      end else begin
         stb_q      <= next_stb;
         sram_stb_q <= next_sram_stb;
      end
   end

   // Write enables live for the whole store sequence in microcode
   always_ff @(posedge clk) begin
      if (RST_I | ~sa14 | buserror) begin
         we_q       <= 1'b0;
         ctrlreg_we <= 1'b0;
      end else if (sa43) begin
         we_q       <= (adr[`PROG_SRAM_BIT] | adr[`PROG_IO_BIT]) & ~misaligned;
         ctrlreg_we <= ctrlreg_hit & ~misaligned;
      end
   end

   assign bus.stb_o    = stb_q;
   assign bus.sram_stb = sram_stb_q;
   assign bus.we_o     = we_q;

   // Only one target can be addressed at a time
   a_one_strobe: assert property (@(posedge clk) disable iff (RST_I)
      !(bus.stb_o && bus.sram_stb))
      else $error("STB_O and sram_stb high together");

endmodule

//--- verilog/byte_lane_sel.sv
`timescale 1ns/100ps
`include "progress_config.svh"

// Byte select decoder for I/O, SRAM and the internal memory
// sel is active high toward the bus, bmask active low toward the EBR
module byte_lane_sel (
   input  logic                    clk,
   input  logic                    RST_I,
   input  logic                    sa41,      // Latch new byte selects
   input  progress_pkg::lane_code_t lane_code, // Access width from microcode
   input  logic [1:0]              adr_lo,    // Low address bits
   output progress_pkg::sel_t      sel,
   output progress_pkg::sel_t      bmask
);

   progress_pkg::sel_t dec_sel; // Combinational decode

   always_comb begin
      dec_sel = '1; // Word access and unknown codes use all lanes
      if (lane_code == `PROG_LANE_HALF) begin
         // Only halfword aligned addresses are legal here
         if (adr_lo == 2'b00) begin
            dec_sel = 4'b0011;
         end else if (adr_lo == 2'b10) begin
            dec_sel = 4'b1100;
         end
      end else if (lane_code == `PROG_LANE_BYTE) begin
         dec_sel = progress_pkg::sel_t'(1) << adr_lo; // One lane at the byte address
      end
   end

   always_ff @(posedge clk) begin
      if (RST_I) begin
         sel   <= '0; // No lanes until the first access
         bmask <= '1;
      end else if (sa41) begin
         sel   <= dec_sel;
         bmask <= ~dec_sel; // Inverse copy, kept as a separate register
      end
   end

   // Both copies must agree in every cycle out of reset
   a_bmask_inverse: assert property (@(posedge clk) disable iff (RST_I) bmask == ~sel)
      else $error("bmask is not the inverse of sel");

endmodule

//--- verilog/progress_pkg.sv
`include "progress_config.svh"

package progress_pkg;

   // Full bus address, as seen on the B bus
   typedef logic [`PROG_ADR_W-1:0] adr_t;

   // One bit per byte lane, bit 0 is the lowest address
   typedef logic [`PROG_SEL_W-1:0] sel_t;

   // Width code from the microcode word, {sa27,sa26,sa25,sa24}
   typedef logic [3:0] lane_code_t;

   // Acknowledge qualifier states
   // ACK_R355 is entered when a slave holds ACK_I high without a strobe
   typedef enum logic {
      ACK_NORMAL = 1'b0, // ACK_I is trusted only together with STB_O
      ACK_R355   = 1'b1  // ACK_I is stuck high, STB_O stands in for it
   } ack_state_e;

endpackage

//--- verilog/bus_cycle_if.sv
`timescale 1ns/100ps

// Status of the current bus cycle, shared by the controller blocks
interface bus_cycle_if;

   logic stb_o;    // I/O strobe
   logic sram_stb; // SRAM strobe
   logic we_o;     // Write enable for I/O or SRAM
   logic qack;     // Qualified acknowledge of the I/O cycle

   // Strobe and write-enable owner
   modport cycle (output stb_o, output sram_stb, output we_o, input qack);

   // Acknowledge qualifier, needs only the I/O strobe
   modport ack (input stb_o, output qack);

   // Microcode progress logic watches for a pending cycle
   modport progress (input stb_o, input sram_stb, input we_o);

endinterface

//--- verilog/progress_config.svh
`ifndef PROGRESS_CONFIG_SVH
`define PROGRESS_CONFIG_SVH

// Bus address width and byte-lane count
`define PROG_ADR_W 32
`define PROG_SEL_W 4

// Address bits that pick the target of a bus cycle
`define PROG_SRAM_BIT 31 // High means SRAM
`define PROG_IO_BIT   30 // High with SRAM bit low means I/O

// Top nibble of the control register region, 0x2xxxxxxx
`define PROG_CTRLREG_REGION 4'h2

// Lane codes from microcode bits sa27..sa24
`define PROG_LANE_HALF 4'h1 // Halfword access
`define PROG_LANE_BYTE 4'h2 // Byte access

`endif
